// File: design/dw_defines.svh
// Bus widths and protocol encodings for the upsizer, included by the package and the testbench
`ifndef DW_DEFINES_SVH
`define DW_DEFINES_SVH

// Address, transaction ID and burst length widths
`define DW_ADDR_W 32
`define DW_ID_W 4
`define DW_LEN_W 8

// Bytes per beat on the narrow and the wide port
`define DW_NARROW_BYTES 4
`define DW_WIDE_BYTES 8
`define DW_WIDE_SIZE 3

// Burst type and response codes
`define DW_BURST_FIXED 2'd0
`define DW_BURST_INCR 2'd1
`define DW_BURST_WRAP 2'd2
`define DW_RESP_OKAY 2'd0
`define DW_RESP_SLVERR 2'd2

`define DW_CACHE_MODIFIABLE_BIT 1

`endif

// File: design/dw_pkg.sv
// Shared channel types and the write FSM states, used by every upsizer module and the testbench
`include "dw_defines.svh"

package dw_pkg;

  // Plain vectors whose width carries a meaning
  typedef logic [`DW_ADDR_W-1:0] addr_t;
  typedef logic [`DW_ID_W-1:0] id_t;
  typedef logic [`DW_LEN_W-1:0] len_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [3:0] cache_t;
  typedef logic [1:0] resp_t;
  typedef logic [8*`DW_NARROW_BYTES-1:0] narrow_data_t;
  typedef logic [`DW_NARROW_BYTES-1:0] narrow_strb_t;
  typedef logic [8*`DW_WIDE_BYTES-1:0] wide_data_t;
  typedef logic [`DW_WIDE_BYTES-1:0] wide_strb_t;
  // Byte lane index inside a wide word
  typedef logic [2:0] lane_t;

  typedef struct packed {
    id_t id;
    addr_t addr;
    len_t len;
    size_t size;
    burst_t burst;
    cache_t cache;
  } aw_chan_t;

  typedef struct packed {
    narrow_data_t data;
    narrow_strb_t strb;
    logic last;
  } narrow_w_t;

  typedef struct packed {
    wide_data_t data;
    wide_strb_t strb;
    logic last;
  } wide_w_t;

  typedef struct packed {
    id_t id;
    resp_t resp;
  } b_chan_t;

  // Decoder verdict, len and size already rewritten for upsized bursts
  typedef struct packed {
    len_t len;
    size_t size;
    logic upsize;
    logic reject;
  } aw_class_t;

  typedef enum logic [1:0] {
    W_IDLE,
    W_PASSTHROUGH,
    W_INCR_UPSIZE,
    W_REJECT
  } w_state_e;

endpackage

// File: design/dw_aw_decode.sv
// Combinational AW classifier that picks upsize, pass-through or reject and rewrites len and size
`include "dw_defines.svh"

module dw_aw_decode (
  input  dw_pkg::aw_chan_t  aw_i,
  output dw_pkg::aw_class_t class_o
);

  dw_pkg::addr_t size_mask;
  dw_pkg::addr_t wide_mask;
  dw_pkg::addr_t last_addr;
  dw_pkg::addr_t span;
  logic          modifiable;
  logic          upsize;
  logic          reject;

  assign modifiable = aw_i.cache[`DW_CACHE_MODIFIABLE_BIT];

  // Only multi-beat bursts are affected
  assign upsize = (aw_i.burst == `DW_BURST_INCR) && modifiable && (aw_i.len != '0);
  assign reject = (aw_i.burst == `DW_BURST_WRAP) && (aw_i.len != '0);

  // Address of the last narrow beat of an INCR burst
  assign size_mask = (dw_pkg::addr_t'(1) << aw_i.size) - dw_pkg::addr_t'(1);
  assign last_addr = (aw_i.addr & ~size_mask) + (dw_pkg::addr_t'(aw_i.len) << aw_i.size);

  // Distance in bytes between the first and the last wide word touched
  assign wide_mask = dw_pkg::addr_t'(`DW_WIDE_BYTES - 1);
  assign span = (last_addr & ~wide_mask) - (aw_i.addr & ~wide_mask);

  always_comb begin
    class_o.upsize = upsize;
    class_o.reject = reject;
    class_o.len    = aw_i.len;
    class_o.size   = aw_i.size;
    if (upsize) begin
      // One wide beat per wide word crossed
      class_o.len  = span[`DW_LEN_W+`DW_WIDE_SIZE-1:`DW_WIDE_SIZE];
      class_o.size = dw_pkg::size_t'(`DW_WIDE_SIZE);
    end
  end

endmodule

// File: design/dw_lane_pack.sv
// Lane steering of one narrow W beat into its byte positions within the wide word
`include "dw_defines.svh"

module dw_lane_pack (
  input  dw_pkg::narrow_w_t  w_i,
  input  dw_pkg::lane_t      wide_lane_i,
  input  dw_pkg::lane_t      narrow_lane_i,
  input  dw_pkg::size_t      size_i,
  output dw_pkg::wide_data_t data_o,
  output dw_pkg::wide_strb_t strb_o
);

  always_comb begin
    int src;
    int dst;

    data_o = '0;
    strb_o = '0;
    src    = 0;
    dst    = 0;
    for (int k = 0; k < `DW_NARROW_BYTES; k++) begin
      src = int'(narrow_lane_i) + k;
      dst = int'(wide_lane_i) + k;
      // Bytes of the beat that are still inside the narrow word
      if ((k < (1 << size_i)) && (src < `DW_NARROW_BYTES)) begin
        data_o[8*dst +: 8] = w_i.data[8*src +: 8];
        strb_o[dst]        = w_i.strb[src];
      end
    end
  end

endmodule

// File: design/dw_err_wresp.sv
// Local SLVERR write response for rejected bursts, merged in front of the wide B channel
`include "dw_defines.svh"

module dw_err_wresp (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            reject_i,
  input  dw_pkg::id_t     reject_id_i,
  input  dw_pkg::b_chan_t mst_b_i,
  input  logic            mst_b_valid_i,
  output logic            mst_b_ready_o,
  output dw_pkg::b_chan_t slv_b_o,
  output logic            slv_b_valid_o,
  input  logic            slv_b_ready_i
);

  logic        err_valid_q;
  dw_pkg::id_t err_id_q;

  // Pending error held until the narrow master takes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_valid_q <= 1'b0;
    end else if (reject_i) begin
      err_valid_q <= 1'b1;
    end else if (slv_b_ready_i) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reject_i) begin
      err_id_q <= reject_id_i;
    end
  end

  // Local response wins, wide B waits behind it
  always_comb begin
    if (err_valid_q) begin
      slv_b_o.id    = err_id_q;
      slv_b_o.resp  = `DW_RESP_SLVERR;
      slv_b_valid_o = 1'b1;
      mst_b_ready_o = 1'b0;
    end else begin
      slv_b_o       = mst_b_i;
      slv_b_valid_o = mst_b_valid_i;
      mst_b_ready_o = slv_b_ready_i;
    end
  end

endmodule

// File: design/dw_w_upsizer.sv
// Write FSM that holds the accepted AW, walks the beat addresses and builds the wide AW and W beats
`include "dw_defines.svh"

module dw_w_upsizer (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  dw_pkg::aw_chan_t   slv_aw_i,
  input  logic               slv_aw_valid_i,
  output logic               slv_aw_ready_o,
  input  logic               slv_w_valid_i,
  output logic               slv_w_ready_o,
  output dw_pkg::aw_chan_t   mst_aw_o,
  output logic               mst_aw_valid_o,
  input  logic               mst_aw_ready_i,
  output dw_pkg::wide_w_t    mst_w_o,
  output logic               mst_w_valid_o,
  input  logic               mst_w_ready_i,
  input  dw_pkg::aw_class_t  class_i,
  output dw_pkg::lane_t      wide_lane_o,
  output dw_pkg::lane_t      narrow_lane_o,
  output dw_pkg::size_t      size_o,
  input  dw_pkg::wide_data_t packed_data_i,
  input  dw_pkg::wide_strb_t packed_strb_i,
  output logic               reject_o,
  output dw_pkg::id_t        reject_id_o
);

  dw_pkg::w_state_e state_q, state_d;
  dw_pkg::aw_chan_t aw_q, aw_d;
  dw_pkg::addr_t    addr_q, addr_d;
  dw_pkg::size_t    size_q, size_d;
  dw_pkg::len_t     beats_q, beats_d;
  dw_pkg::wide_w_t  w_q, w_d;
  logic             aw_valid_q, aw_valid_d;
  logic             w_valid_q, w_valid_d;
  logic             aw_ready_q;
  dw_pkg::addr_t    size_mask;
  dw_pkg::addr_t    addr_step;
  logic             w_fire;
  logic             word_done;

  assign slv_aw_ready_o = aw_ready_q;
  assign mst_aw_o       = aw_q;
  assign mst_aw_valid_o = aw_valid_q;
  assign mst_w_o        = w_q;
  assign mst_w_valid_o  = w_valid_q;
  assign reject_id_o    = aw_q.id;

  // Lane offsets of the current beat
  assign wide_lane_o   = addr_q[`DW_WIDE_SIZE-1:0];
  assign narrow_lane_o = wide_lane_o & dw_pkg::lane_t'(`DW_NARROW_BYTES - 1);
  assign size_o        = size_q;

  // Next INCR beat starts at the next size-aligned address
  assign size_mask = (dw_pkg::addr_t'(1) << size_q) - dw_pkg::addr_t'(1);
  assign addr_step = (addr_q & ~size_mask) + (dw_pkg::addr_t'(1) << size_q);

  assign w_fire    = w_valid_q && mst_w_ready_i;
  assign word_done = (beats_q == '0) ||
                     (addr_step[`DW_ADDR_W-1:`DW_WIDE_SIZE] != addr_q[`DW_ADDR_W-1:`DW_WIDE_SIZE]);

  always_comb begin
    state_d       = state_q;
    aw_d          = aw_q;
    addr_d        = addr_q;
    size_d        = size_q;
    beats_d       = beats_q;
    w_d           = w_q;
    aw_valid_d    = aw_valid_q;
    w_valid_d     = w_valid_q;
    slv_w_ready_o = 1'b0;
    reject_o      = 1'b0;

    if (aw_valid_q && mst_aw_ready_i) begin
      aw_valid_d = 1'b0;
    end

    // A sent wide beat frees the word for the next merge
    if (w_fire) begin
      w_d       = '0;
      w_valid_d = 1'b0;
    end

    case (state_q)
      dw_pkg::W_IDLE: begin
        if (slv_aw_valid_i && slv_aw_ready_o) begin
          aw_d      = slv_aw_i;
          aw_d.len  = class_i.len;
          aw_d.size = class_i.size;
          addr_d    = slv_aw_i.addr;
          size_d    = slv_aw_i.size;
          beats_d   = slv_aw_i.len;
          w_d       = '0;
          if (class_i.reject) begin
            state_d = dw_pkg::W_REJECT;
          end else begin
            aw_valid_d = 1'b1;
            state_d    = class_i.upsize ? dw_pkg::W_INCR_UPSIZE : dw_pkg::W_PASSTHROUGH;
          end
        end
      end

      dw_pkg::W_PASSTHROUGH, dw_pkg::W_INCR_UPSIZE: begin
        // Wait for the wide AW, then stall behind a pending wide beat
        slv_w_ready_o = !aw_valid_q && (!w_valid_q || (mst_w_ready_i && !w_q.last));
        if (slv_w_valid_i && slv_w_ready_o) begin
          w_d.data = w_d.data | packed_data_i;
          w_d.strb = w_d.strb | packed_strb_i;
          w_d.last = (beats_q == '0);
          beats_d  = beats_q - 1'b1;
          if (aw_q.burst == `DW_BURST_INCR) begin
            addr_d = addr_step;
          end
          if ((state_q == dw_pkg::W_PASSTHROUGH) || word_done) begin
            w_valid_d = 1'b1;
          end
        end
        if (w_fire && w_q.last) begin
          state_d = dw_pkg::W_IDLE;
        end
      end

      dw_pkg::W_REJECT: begin
        // Swallow the beats, the error responder answers
        slv_w_ready_o = 1'b1;
        if (slv_w_valid_i) begin
          beats_d = beats_q - 1'b1;
          if (beats_q == '0) begin
            reject_o = 1'b1;
            state_d  = dw_pkg::W_IDLE;
          end
        end
      end

      default: state_d = dw_pkg::W_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= dw_pkg::W_IDLE;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      aw_ready_q <= 1'b0;
      beats_q    <= '0;
    end else begin
      state_q    <= state_d;
      aw_valid_q <= aw_valid_d;
      w_valid_q  <= w_valid_d;
      aw_ready_q <= (state_d == dw_pkg::W_IDLE);
      beats_q    <= beats_d;
    end
  end

  always_ff @(posedge clk_i) begin
    aw_q   <= aw_d;
    addr_q <= addr_d;
    size_q <= size_d;
    w_q    <= w_d;
  end

endmodule

// File: design/dw_upsizer_top.sv
// Write-side 32 to 64 bit upsizer top level, to be placed between a narrow master and a wide slave
`include "dw_defines.svh"

module dw_upsizer_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Narrow port
  input  dw_pkg::aw_chan_t   slv_aw_i,
  input  logic               slv_aw_valid_i,
  output logic               slv_aw_ready_o,
  input  dw_pkg::narrow_w_t  slv_w_i,
  input  logic               slv_w_valid_i,
  output logic               slv_w_ready_o,
  output dw_pkg::b_chan_t    slv_b_o,
  output logic               slv_b_valid_o,
  input  logic               slv_b_ready_i,
  // Wide port
  output dw_pkg::aw_chan_t   mst_aw_o,
  output logic               mst_aw_valid_o,
  input  logic               mst_aw_ready_i,
  output dw_pkg::wide_w_t    mst_w_o,
  output logic               mst_w_valid_o,
  input  logic               mst_w_ready_i,
  input  dw_pkg::b_chan_t    mst_b_i,
  input  logic               mst_b_valid_i,
  output logic               mst_b_ready_o
);

  dw_pkg::aw_class_t  aw_class;
  dw_pkg::lane_t      wide_lane;
  dw_pkg::lane_t      narrow_lane;
  dw_pkg::size_t      beat_size;
  dw_pkg::wide_data_t packed_data;
  dw_pkg::wide_strb_t packed_strb;
  logic               reject;
  dw_pkg::id_t        reject_id;

  dw_aw_decode u_aw_decode (
    .aw_i    (slv_aw_i),
    .class_o (aw_class)
  );

  dw_w_upsizer u_w_upsizer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_i       (slv_aw_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_ready_o  (slv_w_ready_o),
    .mst_aw_o       (mst_aw_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .mst_w_o        (mst_w_o),
    .mst_w_valid_o  (mst_w_valid_o),
    .mst_w_ready_i  (mst_w_ready_i),
    .class_i        (aw_class),
    .wide_lane_o    (wide_lane),
    .narrow_lane_o  (narrow_lane),
    .size_o         (beat_size),
    .packed_data_i  (packed_data),
    .packed_strb_i  (packed_strb),
    .reject_o       (reject),
    .reject_id_o    (reject_id)
  );

  dw_lane_pack u_lane_pack (
    .w_i           (slv_w_i),
    .wide_lane_i   (wide_lane),
    .narrow_lane_i (narrow_lane),
    .size_i        (beat_size),
    .data_o        (packed_data),
    .strb_o        (packed_strb)
  );

  dw_err_wresp u_err_wresp (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .reject_i      (reject),
    .reject_id_i   (reject_id),
    .mst_b_i       (mst_b_i),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_ready_o (mst_b_ready_o),
    .slv_b_o       (slv_b_o),
    .slv_b_valid_o (slv_b_valid_o),
    .slv_b_ready_i (slv_b_ready_i)
  );

endmodule

// File: sim/tb_dw_checker.sv
// Reference model instantiated by the testbench top that compares the wide AW, W and narrow B
`include "dw_defines.svh"

module tb_dw_checker (
  input logic              clk_i,
  input logic              rst_ni,
  input dw_pkg::aw_chan_t  slv_aw_i,
  input logic              slv_aw_valid_i,
  input logic              slv_aw_ready_i,
  input dw_pkg::narrow_w_t slv_w_i,
  input logic              slv_w_valid_i,
  input logic              slv_w_ready_i,
  input dw_pkg::b_chan_t   slv_b_i,
  input logic              slv_b_valid_i,
  input logic              slv_b_ready_i,
  input dw_pkg::aw_chan_t  mst_aw_i,
  input logic              mst_aw_valid_i,
  input logic              mst_aw_ready_i,
  input dw_pkg::wide_w_t   mst_w_i,
  input logic              mst_w_valid_i,
  input logic              mst_w_ready_i,
  input logic              mst_b_ready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int errors = 0;
  int b_count = 0;
  int after_reset = 0;
  int burst_idx = 0;

  // Expected transfers tagged with the burst they belong to
  dw_pkg::aw_chan_t exp_aw[$];
  int               exp_aw_idx[$];
  dw_pkg::wide_w_t  exp_w[$];
  int               exp_w_idx[$];
  int               exp_beats[$];
  dw_pkg::b_chan_t  exp_b[$];
  int               exp_b_idx[$];

  // Burst currently on the narrow W channel
  dw_pkg::aw_chan_t cur;
  int               cur_idx;
  int               beat;
  logic             cur_up;
  logic             cur_rej;
  dw_pkg::wide_w_t  pend;
  int               w_beats = 0;
  // Local SLVERR response owed to the narrow side
  logic             err_pend = 1'b0;

  function automatic string test_name(input int idx);
    return $sformatf("burst_%0d", idx);
  endfunction

  // AXI beat address aligned to the size after the first INCR beat
  function automatic dw_pkg::addr_t narrow_beat_addr(input dw_pkg::aw_chan_t aw, input int i);
    dw_pkg::addr_t base;
    base = aw.addr & ~((dw_pkg::addr_t'(1) << aw.size) - dw_pkg::addr_t'(1));
    if ((aw.burst != `DW_BURST_INCR) || (i == 0)) begin
      return aw.addr;
    end
    return base + (dw_pkg::addr_t'(i) << aw.size);
  endfunction

  task automatic compare(input string test, input string field, input logic [79:0] exp,
                         input logic [79:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", test, field, exp, act);
      errors++;
    end
  endtask

  task automatic complain(input string what);
    $display("Unexpected event: %s", what);
    errors++;
  endtask

  task automatic start_burst(input dw_pkg::aw_chan_t aw);
    dw_pkg::aw_chan_t wide;
    dw_pkg::b_chan_t  b;
    dw_pkg::addr_t    last;
    cur     = aw;
    cur_idx = burst_idx;
    burst_idx++;
    beat    = 0;
    pend    = '0;
    cur_up  = (aw.burst == `DW_BURST_INCR) && aw.cache[`DW_CACHE_MODIFIABLE_BIT] && (aw.len != 0);
    cur_rej = (aw.burst == `DW_BURST_WRAP) && (aw.len != 0);
    b.id    = aw.id;
    b.resp  = cur_rej ? `DW_RESP_SLVERR : `DW_RESP_OKAY;
    exp_b.push_back(b);
    exp_b_idx.push_back(cur_idx);
    if (!cur_rej) begin
      wide = aw;
      if (cur_up) begin
        // Wide words between the first and the last narrow beat
        last      = narrow_beat_addr(aw, aw.len);
        wide.len  = dw_pkg::len_t'((last >> 3) - (aw.addr >> 3));
        wide.size = dw_pkg::size_t'(`DW_WIDE_SIZE);
      end
      exp_aw.push_back(wide);
      exp_aw_idx.push_back(cur_idx);
      exp_beats.push_back(int'(wide.len) + 1);
    end
  endtask

  task automatic narrow_beat(input dw_pkg::narrow_w_t w);
    dw_pkg::addr_t a;
    int            nl;
    int            wl;
    logic          done;
    a = narrow_beat_addr(cur, beat);
    if (!cur_rej) begin
      for (int k = 0; k < (1 << cur.size); k++) begin
        nl = int'(a[1:0]) + k;
        wl = int'(a[2:0]) + k;
        if (nl < `DW_NARROW_BYTES) begin
          pend.data[8*wl +: 8] = w.data[8*nl +: 8];
          pend.strb[wl]        = w.strb[nl];
        end
      end
      done = !cur_up || (beat == cur.len) ||
             ((narrow_beat_addr(cur, beat + 1) >> 3) != (a >> 3));
      if (done) begin
        pend.last = (beat == cur.len);
        exp_w.push_back(pend);
        exp_w_idx.push_back(cur_idx);
        pend = '0;
      end
    end
    if (cur_rej && (beat == cur.len)) begin
      err_pend = 1'b1;
    end
    beat++;
  endtask

  task automatic check_drained();
    if ((exp_aw.size() != 0) || (exp_w.size() != 0) || (exp_b.size() != 0)) begin
      $display("Transfers never seen at end of run: %0d wide AW, %0d wide W, %0d narrow B",
               exp_aw.size(), exp_w.size(), exp_b.size());
      errors++;
    end
  endtask

  // Mid-cycle sampling where every fire seen transfers at the next rising edge
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      after_reset = 0;
      compare("reset", "valids and readys", 5'b0,
              {mst_aw_valid_i, mst_w_valid_i, slv_b_valid_i, slv_aw_ready_i, slv_w_ready_i});
    end else begin
      if (after_reset < 2) begin
        compare("reset", "valids", 3'b0, {mst_aw_valid_i, mst_w_valid_i, slv_b_valid_i});
        if (after_reset == 1) begin
          compare("reset", "narrow aw_ready", 1'b1, slv_aw_ready_i);
        end
        after_reset++;
      end
      // Wide B is held off while the local error response is pending
      compare(test_name(cur_idx), "wide b_ready", slv_b_ready_i && !err_pend, mst_b_ready_i);
      if (slv_aw_valid_i && slv_aw_ready_i) begin
        start_burst(slv_aw_i);
      end
      if (slv_w_valid_i && slv_w_ready_i) begin
        narrow_beat(slv_w_i);
      end
      if (mst_aw_valid_i && mst_aw_ready_i) begin
        if (exp_aw.size() == 0) begin
          complain("wide AW transferred with no forwarded burst waiting for it");
        end else begin
          compare(test_name(exp_aw_idx[0]), "wide AW", exp_aw[0], mst_aw_i);
          exp_aw.delete(0);
          exp_aw_idx.delete(0);
        end
      end
      if (mst_w_valid_i && mst_w_ready_i) begin
        w_beats++;
        if (exp_w.size() == 0) begin
          complain("wide W beat transferred with no narrow data behind it");
        end else begin
          compare(test_name(exp_w_idx[0]), "wide W", exp_w[0], mst_w_i);
          if (mst_w_i.last && (exp_beats.size() != 0)) begin
            compare(test_name(exp_w_idx[0]), "wide W beat count", exp_beats[0], w_beats);
            exp_beats.delete(0);
          end
          exp_w.delete(0);
          exp_w_idx.delete(0);
        end
        if (mst_w_i.last) begin
          w_beats = 0;
        end
      end
      if (slv_b_valid_i && slv_b_ready_i) begin
        b_count++;
        if (exp_b.size() == 0) begin
          complain("narrow B returned for no burst");
        end else begin
          compare(test_name(exp_b_idx[0]), "narrow B", exp_b[0], slv_b_i);
          if (exp_b[0].resp == `DW_RESP_SLVERR) begin
            err_pend = 1'b0;
          end
          exp_b.delete(0);
          exp_b_idx.delete(0);
        end
      end
    end
  end

endmodule

// File: sim/tb_dw_upsizer.sv
// Testbench top that drives random narrow bursts into the write upsizer and plays a wide slave
`include "dw_defines.svh"

module tb_dw_upsizer;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_BURSTS = 60;
  localparam int TIMEOUT    = 200;

  logic              clk;
  logic              rst_n;
  dw_pkg::aw_chan_t  slv_aw;
  logic              slv_aw_valid;
  logic              slv_aw_ready;
  dw_pkg::narrow_w_t slv_w;
  logic              slv_w_valid;
  logic              slv_w_ready;
  dw_pkg::b_chan_t   slv_b;
  logic              slv_b_valid;
  logic              slv_b_ready;
  dw_pkg::aw_chan_t  mst_aw;
  logic              mst_aw_valid;
  logic              mst_aw_ready;
  dw_pkg::wide_w_t   mst_w;
  logic              mst_w_valid;
  logic              mst_w_ready;
  dw_pkg::b_chan_t   mst_b;
  logic              mst_b_valid;
  logic              mst_b_ready;

  integer            seed;
  integer            ready_seed;
  int                tests_run = 0;
  int                tests_failed = 0;
  int                errors_seen = 0;
  dw_pkg::id_t       aw_ids[$];
  dw_pkg::id_t       b_ids[$];

  dw_upsizer_top u_dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .slv_aw_i       (slv_aw),
    .slv_aw_valid_i (slv_aw_valid),
    .slv_aw_ready_o (slv_aw_ready),
    .slv_w_i        (slv_w),
    .slv_w_valid_i  (slv_w_valid),
    .slv_w_ready_o  (slv_w_ready),
    .slv_b_o        (slv_b),
    .slv_b_valid_o  (slv_b_valid),
    .slv_b_ready_i  (slv_b_ready),
    .mst_aw_o       (mst_aw),
    .mst_aw_valid_o (mst_aw_valid),
    .mst_aw_ready_i (mst_aw_ready),
    .mst_w_o        (mst_w),
    .mst_w_valid_o  (mst_w_valid),
    .mst_w_ready_i  (mst_w_ready),
    .mst_b_i        (mst_b),
    .mst_b_valid_i  (mst_b_valid),
    .mst_b_ready_o  (mst_b_ready)
  );

  tb_dw_checker u_checker (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .slv_aw_i       (slv_aw),
    .slv_aw_valid_i (slv_aw_valid),
    .slv_aw_ready_i (slv_aw_ready),
    .slv_w_i        (slv_w),
    .slv_w_valid_i  (slv_w_valid),
    .slv_w_ready_i  (slv_w_ready),
    .slv_b_i        (slv_b),
    .slv_b_valid_i  (slv_b_valid),
    .slv_b_ready_i  (slv_b_ready),
    .mst_aw_i       (mst_aw),
    .mst_aw_valid_i (mst_aw_valid),
    .mst_aw_ready_i (mst_aw_ready),
    .mst_w_i        (mst_w),
    .mst_w_valid_i  (mst_w_valid),
    .mst_w_ready_i  (mst_w_ready),
    .mst_b_ready_i  (mst_b_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort(input string why);
    $display("TIMEOUT: %s", why);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (u_checker.errors == errors_seen) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d failed checks", name, u_checker.errors - errors_seen);
    end
    errors_seen = u_checker.errors;
  endtask

  // Holds the current valid until the DUT takes it and steps to the next drive point
  task automatic wait_accept(input bit is_aw, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!(is_aw ? slv_aw_ready : slv_w_ready)) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        abort({what, " was not accepted by the DUT"});
      end
      @(negedge clk);
    end
    @(posedge clk);
    #10;
  endtask

  task automatic wait_b_count(input int count, input string name);
    int cycles;
    cycles = 0;
    while (u_checker.b_count < count) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        abort({"no narrow B arrived for ", name});
      end
      @(posedge clk);
    end
    #10;
  endtask

  task automatic send_burst(input int idx);
    dw_pkg::aw_chan_t aw;
    string            name;
    name     = $sformatf("burst_%0d", idx);
    aw.id    = $random(seed);
    aw.burst = dw_pkg::burst_t'(($random(seed) & 32'h7fff_ffff) % 3);
    aw.cache = $random(seed);
    aw.len   = $random(seed) & 7;
    aw.size  = dw_pkg::size_t'(($random(seed) & 32'h7fff_ffff) % 3);
    aw.addr  = $random(seed) & 32'h0000_ffff;
    aw.addr  = aw.addr & ~((32'd1 << aw.size) - 32'd1);
    slv_aw       = aw;
    slv_aw_valid = 1'b1;
    wait_accept(1'b1, {"narrow AW of ", name});
    slv_aw_valid = 1'b0;
    for (int i = 0; i <= int'(aw.len); i++) begin
      if (($random(seed) & 3) == 0) begin
        @(posedge clk);
        #10;
      end
      slv_w.data  = $random(seed);
      slv_w.strb  = $random(seed);
      slv_w.last  = (i == int'(aw.len));
      slv_w_valid = 1'b1;
      wait_accept(1'b0, {"narrow W of ", name});
      slv_w_valid = 1'b0;
    end
    wait_b_count(idx + 1, name);
    finish_test(name);
  endtask

  // Wide slave with random stalls that returns one OKAY per wide last beat
  always begin : wide_slave
    logic        aw_fire;
    logic        last_fire;
    logic        b_fire;
    dw_pkg::id_t aw_id;
    @(negedge clk);
    aw_fire   = rst_n && mst_aw_valid && mst_aw_ready;
    last_fire = rst_n && mst_w_valid && mst_w_ready && mst_w.last;
    b_fire    = mst_b_valid && mst_b_ready;
    aw_id     = mst_aw.id;
    @(posedge clk);
    #10;
    if (aw_fire) begin
      aw_ids.push_back(aw_id);
    end
    if (b_fire && (b_ids.size() != 0)) begin
      b_ids.delete(0);
    end
    if (last_fire && (aw_ids.size() != 0)) begin
      b_ids.push_back(aw_ids[0]);
      aw_ids.delete(0);
    end
    mst_b_valid  = (b_ids.size() != 0);
    mst_b.id     = (b_ids.size() != 0) ? b_ids[0] : '0;
    mst_b.resp   = `DW_RESP_OKAY;
    mst_aw_ready = rst_n && (($random(ready_seed) & 3) != 0);
    mst_w_ready  = rst_n && (($random(ready_seed) & 3) != 0);
  end

  initial begin : stimulus
    seed         = 32'ha155_89f2;
    ready_seed   = seed ^ 32'hffff_ffff;
    rst_n        = 1'b0;
    slv_aw       = '0;
    slv_aw_valid = 1'b0;
    slv_w        = '0;
    slv_w_valid  = 1'b0;
    slv_b_ready  = 1'b1;
    mst_aw_ready = 1'b0;
    mst_w_ready  = 1'b0;
    mst_b        = '0;
    mst_b_valid  = 1'b0;
    repeat (4) @(posedge clk);
    #10;
    rst_n = 1'b1;
    repeat (2) @(posedge clk);
    #10;
    finish_test("reset");
    for (int i = 0; i < NUM_BURSTS; i++) begin
      send_burst(i);
    end
    u_checker.check_drained();
    finish_test("drain");
    $display("Tests run: %0d, passed: %0d, failed: %0d, failed checks: %0d",
             tests_run, tests_run - tests_failed, tests_failed, u_checker.errors);
    if ((tests_failed == 0) && (u_checker.errors == 0)) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+design
design/dw_pkg.sv
design/dw_aw_decode.sv
design/dw_lane_pack.sv
design/dw_err_wresp.sv
design/dw_w_upsizer.sv
design/dw_upsizer_top.sv
sim/tb_dw_checker.sv
sim/tb_dw_upsizer.sv
